// ==== rtl/dispatch_cfg_pkg.sv ====
package dispatch_cfg_pkg;

   // reorder buffer
   localparam int ROB_DEPTH = 16;
   // ids carry one extra wrap bit on top of this
   localparam int ROB_WIDTH = 4;

   // physical register file
   localparam int PRF_DEPTH = 64;
   localparam int PRF_WIDTH = 6;

   // issue queues
   localparam int INT_ISQ_DEPTH = 8;
   localparam int MEM_ISQ_DEPTH = 4;

   // store queue
   localparam int SQ_DEPTH = 8;
   localparam int SQ_WIDTH = 3;

endpackage

// ==== rtl/ooo_types_pkg.sv ====
package ooo_types_pkg;

   import dispatch_cfg_pkg::*;

   // physical register tag
   typedef logic [PRF_WIDTH-1:0] preg_t;

   // rob id, msb is the wrap bit
   typedef logic [ROB_WIDTH:0] rob_id_t;

   // store queue id
   typedef logic [SQ_WIDTH-1:0] sq_id_t;

   // free entries, saturated at 2
   typedef logic [1:0] left_t;

   // 0, 1 or 2 per cycle
   typedef logic [1:0] pair_cnt_t;

endpackage

// ==== rtl/dispatch.sv ====
`timescale 1ns/1ps

module dispatch
   import ooo_types_pkg::*;
(
   input  logic  instr0_valid,
   input  logic  instr1_valid,
   input  logic  instr0_mem_read,
   input  logic  instr0_mem_write,
   input  logic  instr1_mem_read,
   input  logic  instr1_mem_write,

   input  left_t rob_left,
   input  left_t int_isq_left,
   input  left_t mem_isq_left,
   input  left_t sq_left,

   output logic  can_dispatch,
   output logic  instr0_valid_rob,
   output logic  instr1_valid_rob,
   output logic  instr0_valid_intisq,
   output logic  instr1_valid_intisq,
   output logic  instr0_valid_memisq,
   output logic  instr1_valid_memisq
);

   logic [1:0] mem_vec;
   logic [1:0] int_vec;

   pair_cnt_t mem_num;
   pair_cnt_t int_num;
   pair_cnt_t all_num;

   logic rob_ok;
   logic int_isq_ok;
   logic mem_isq_ok;
   logic sq_ok;

   // loads and stores go to the memory side, everything else is integer
   always_comb begin
      mem_vec = '0;
      int_vec = '0;
      if (instr0_valid && (instr0_mem_read || instr0_mem_write)) begin
         mem_vec[0] = 1'b1;
      end else if (instr0_valid) begin
         int_vec[0] = 1'b1;
      end
      if (instr1_valid && (instr1_mem_read || instr1_mem_write)) begin
         mem_vec[1] = 1'b1;
      end else if (instr1_valid) begin
         int_vec[1] = 1'b1;
      end
   end

   assign mem_num = {1'b0, mem_vec[1]} + {1'b0, mem_vec[0]};
   assign int_num = {1'b0, int_vec[1]} + {1'b0, int_vec[0]};
   assign all_num = mem_num + int_num;

   // whole pair or nothing
   assign rob_ok     = (rob_left >= all_num);
   assign int_isq_ok = (int_isq_left >= int_num);
   assign mem_isq_ok = (mem_isq_left >= mem_num);
   // every memory op reserves a store queue slot
   assign sq_ok      = (sq_left >= mem_num);

   assign can_dispatch = rob_ok & int_isq_ok & mem_isq_ok & sq_ok;

   assign instr0_valid_rob = instr0_valid & can_dispatch;
   assign instr1_valid_rob = instr1_valid & can_dispatch;

   assign instr0_valid_intisq = instr0_valid_rob & int_vec[0];
   assign instr1_valid_intisq = instr1_valid_rob & int_vec[1];
   assign instr0_valid_memisq = instr0_valid_rob & mem_vec[0];
   assign instr1_valid_memisq = instr1_valid_rob & mem_vec[1];

endmodule

// ==== rtl/slot_allocator.sv ====
`timescale 1ns/1ps

module slot_allocator
   import dispatch_cfg_pkg::*;
   import ooo_types_pkg::*;
#(
   parameter int DEPTH = ROB_DEPTH,
   // includes the wrap bit where the id has one
   parameter int ID_W  = ROB_WIDTH + 1
) (
   input  logic            clk,
   input  logic            rst_n,

   input  logic            alloc0,
   input  logic            alloc1,
   input  pair_cnt_t       free_num,

   output left_t           left,
   output logic [ID_W-1:0] id0,
   output logic [ID_W-1:0] id1
);

   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [ID_W-1:0]  tail;
   logic [CNT_W-1:0] occ;
   logic [CNT_W-1:0] free_cnt;
   pair_cnt_t        alloc_num;

   assign alloc_num = {1'b0, alloc0} + {1'b0, alloc1};

   assign free_cnt = CNT_W'(DEPTH) - occ;

   // only 0, 1 or 2 matters to dispatch
   assign left = (free_cnt >= CNT_W'(2)) ? 2'd2 : left_t'(free_cnt);

   // slot 1 follows slot 0 only if slot 0 took an entry
   assign id0 = tail;
   assign id1 = alloc0 ? tail + ID_W'(1) : tail;

   // depths are powers of two, so the tail wraps on its own
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tail <= '0;
      end else begin
         tail <= tail + ID_W'(alloc_num);
      end
   end

   // frees never exceed occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         occ <= '0;
      end else begin
         occ <= occ - CNT_W'(free_num) + CNT_W'(alloc_num);
      end
   end

endmodule

// ==== rtl/busy_table.sv ====
`timescale 1ns/1ps

module busy_table
   import dispatch_cfg_pkg::*;
   import ooo_types_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,

   // destinations of the dispatching pair
   input  logic  set0_valid,
   input  logic  set1_valid,
   input  preg_t set0_tag,
   input  preg_t set1_tag,

   // writeback clears
   input  logic  wb_valid,
   input  preg_t wb_tag,

   input  preg_t instr0_src1,
   input  preg_t instr0_src2,
   input  preg_t instr1_src1,
   input  preg_t instr1_src2,

   output logic  instr0_src1_busy,
   output logic  instr0_src2_busy,
   output logic  instr1_src1_busy,
   output logic  instr1_src2_busy
);

   logic [PRF_DEPTH-1:0] busy;

   logic wb_hit_01;
   logic wb_hit_02;
   logic wb_hit_11;
   logic wb_hit_12;
   logic byp_11;
   logic byp_12;

   // set is applied after clear so it wins on a shared tag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         if (wb_valid) begin
            busy[wb_tag] <= 1'b0;
         end
         if (set0_valid) begin
            busy[set0_tag] <= 1'b1;
         end
         if (set1_valid) begin
            busy[set1_tag] <= 1'b1;
         end
      end
   end

   // result arriving this cycle
   assign wb_hit_01 = wb_valid && (wb_tag == instr0_src1);
   assign wb_hit_02 = wb_valid && (wb_tag == instr0_src2);
   assign wb_hit_11 = wb_valid && (wb_tag == instr1_src1);
   assign wb_hit_12 = wb_valid && (wb_tag == instr1_src2);

   // instr1 reading what instr0 writes in the same pair
   assign byp_11 = set0_valid && (set0_tag == instr1_src1);
   assign byp_12 = set0_valid && (set0_tag == instr1_src2);

   assign instr0_src1_busy = busy[instr0_src1] & ~wb_hit_01;
   assign instr0_src2_busy = busy[instr0_src2] & ~wb_hit_02;
   assign instr1_src1_busy = (busy[instr1_src1] & ~wb_hit_11) | byp_11;
   assign instr1_src2_busy = (busy[instr1_src2] & ~wb_hit_12) | byp_12;

endmodule

// ==== rtl/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage
   import dispatch_cfg_pkg::*;
   import ooo_types_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // from rename
   input  logic      instr0_valid,
   input  logic      instr0_mem_read,
   input  logic      instr0_mem_write,
   input  preg_t     instr0_T,
   input  preg_t     instr0_T_old,
   input  preg_t     instr0_src1,
   input  preg_t     instr0_src2,
   input  logic      instr1_valid,
   input  logic      instr1_mem_read,
   input  logic      instr1_mem_write,
   input  preg_t     instr1_T,
   input  preg_t     instr1_T_old,
   input  preg_t     instr1_src1,
   input  preg_t     instr1_src2,

   // releases from the back end
   input  pair_cnt_t rob_free_num,
   input  pair_cnt_t int_isq_free_num,
   input  pair_cnt_t mem_isq_free_num,
   input  pair_cnt_t sq_free_num,

   input  logic      wb_valid,
   input  preg_t     wb_tag,

   output logic      can_dispatch,
   output logic      instr0_valid_rob,
   output logic      instr1_valid_rob,
   output logic      instr0_valid_intisq,
   output logic      instr1_valid_intisq,
   output logic      instr0_valid_memisq,
   output logic      instr1_valid_memisq,

   output rob_id_t   instr0_robid,
   output rob_id_t   instr1_robid,
   output sq_id_t    instr0_sqid,
   output sq_id_t    instr1_sqid,

   // rob keeps the old mapping for release at commit
   output preg_t     instr0_T_rob,
   output preg_t     instr0_T_old_rob,
   output preg_t     instr1_T_rob,
   output preg_t     instr1_T_old_rob,

   output logic      instr0_src1_busy,
   output logic      instr0_src2_busy,
   output logic      instr1_src1_busy,
   output logic      instr1_src2_busy
);

   left_t rob_left;
   left_t int_isq_left;
   left_t mem_isq_left;
   left_t sq_left;

   dispatch dispatch_i (
      .instr0_valid        (instr0_valid),
      .instr1_valid        (instr1_valid),
      .instr0_mem_read     (instr0_mem_read),
      .instr0_mem_write    (instr0_mem_write),
      .instr1_mem_read     (instr1_mem_read),
      .instr1_mem_write    (instr1_mem_write),
      .rob_left            (rob_left),
      .int_isq_left        (int_isq_left),
      .mem_isq_left        (mem_isq_left),
      .sq_left             (sq_left),
      .can_dispatch        (can_dispatch),
      .instr0_valid_rob    (instr0_valid_rob),
      .instr1_valid_rob    (instr1_valid_rob),
      .instr0_valid_intisq (instr0_valid_intisq),
      .instr1_valid_intisq (instr1_valid_intisq),
      .instr0_valid_memisq (instr0_valid_memisq),
      .instr1_valid_memisq (instr1_valid_memisq)
   );

   slot_allocator #(.DEPTH(ROB_DEPTH), .ID_W(ROB_WIDTH + 1)) rob_alloc_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .alloc0   (instr0_valid_rob),
      .alloc1   (instr1_valid_rob),
      .free_num (rob_free_num),
      .left     (rob_left),
      .id0      (instr0_robid),
      .id1      (instr1_robid)
   );

   // queue slot ids are assigned inside the queues, only the count is used here
   slot_allocator #(.DEPTH(INT_ISQ_DEPTH), .ID_W($clog2(INT_ISQ_DEPTH))) int_isq_alloc_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .alloc0   (instr0_valid_intisq),
      .alloc1   (instr1_valid_intisq),
      .free_num (int_isq_free_num),
      .left     (int_isq_left),
      .id0      (),
      .id1      ()
   );

   slot_allocator #(.DEPTH(MEM_ISQ_DEPTH), .ID_W($clog2(MEM_ISQ_DEPTH))) mem_isq_alloc_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .alloc0   (instr0_valid_memisq),
      .alloc1   (instr1_valid_memisq),
      .free_num (mem_isq_free_num),
      .left     (mem_isq_left),
      .id0      (),
      .id1      ()
   );

   // loads take a store queue id too, for ordering
   slot_allocator #(.DEPTH(SQ_DEPTH), .ID_W(SQ_WIDTH)) sq_alloc_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .alloc0   (instr0_valid_memisq),
      .alloc1   (instr1_valid_memisq),
      .free_num (sq_free_num),
      .left     (sq_left),
      .id0      (instr0_sqid),
      .id1      (instr1_sqid)
   );

   busy_table busy_table_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .set0_valid       (instr0_valid_rob),
      .set1_valid       (instr1_valid_rob),
      .set0_tag         (instr0_T),
      .set1_tag         (instr1_T),
      .wb_valid         (wb_valid),
      .wb_tag           (wb_tag),
      .instr0_src1      (instr0_src1),
      .instr0_src2      (instr0_src2),
      .instr1_src1      (instr1_src1),
      .instr1_src2      (instr1_src2),
      .instr0_src1_busy (instr0_src1_busy),
      .instr0_src2_busy (instr0_src2_busy),
      .instr1_src1_busy (instr1_src1_busy),
      .instr1_src2_busy (instr1_src2_busy)
   );

   // each slot carries its own destination
   assign instr0_T_rob     = instr0_T;
   assign instr0_T_old_rob = instr0_T_old;
   assign instr1_T_rob     = instr1_T;
   assign instr1_T_old_rob = instr1_T_old;

endmodule

// ==== sim/dispatch_stage_asserts.sv ====
`timescale 1ns/1ps

module dispatch_stage_asserts
   import dispatch_cfg_pkg::*;
   import ooo_types_pkg::*;
(
   input logic      clk, rst_n, can_dispatch,
   input logic      instr0_valid_rob, instr1_valid_rob,
   input logic      instr0_valid_intisq, instr1_valid_intisq,
   input logic      instr0_valid_memisq, instr1_valid_memisq,
   input rob_id_t   instr0_robid,
   input sq_id_t    instr0_sqid,
   input pair_cnt_t rob_free_num, int_isq_free_num, mem_isq_free_num, sq_free_num,
   input logic [$clog2(ROB_DEPTH+1)-1:0]     rob_occ,
   input logic [$clog2(INT_ISQ_DEPTH+1)-1:0] int_isq_occ,
   input logic [$clog2(MEM_ISQ_DEPTH+1)-1:0] mem_isq_occ,
   input logic [$clog2(SQ_DEPTH+1)-1:0]      sq_occ
);

   // a strobe only lands where there is room
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      (int'(rob_occ) + int'(instr0_valid_rob) + int'(instr1_valid_rob)
         <= ROB_DEPTH)
      && (int'(int_isq_occ) + int'(instr0_valid_intisq) + int'(instr1_valid_intisq)
         <= INT_ISQ_DEPTH)
      && (int'(mem_isq_occ) + int'(instr0_valid_memisq) + int'(instr1_valid_memisq)
         <= MEM_ISQ_DEPTH)
      && (int'(sq_occ) + int'(instr0_valid_memisq) + int'(instr1_valid_memisq)
         <= SQ_DEPTH))
      else $error("strobe into a full structure");

   // a dispatched slot lands in exactly one issue queue
   a_one_queue: assert property (@(posedge clk) disable iff (!rst_n)
      (instr0_valid_rob == (instr0_valid_intisq ^ instr0_valid_memisq))
      && (instr1_valid_rob == (instr1_valid_intisq ^ instr1_valid_memisq)))
      else $error("slot strobed to both or neither issue queue");

   a_free_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (int'(rob_free_num) <= int'(rob_occ)) && (int'(int_isq_free_num) <= int'(int_isq_occ))
      && (int'(mem_isq_free_num) <= int'(mem_isq_occ)) && (int'(sq_free_num) <= int'(sq_occ)))
      else $error("free count exceeds occupancy");

   // tails hold and counts only drop by the frees
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !can_dispatch |=> $stable(instr0_robid) && $stable(instr0_sqid)
      && (rob_occ == $past(rob_occ) - $past(rob_free_num))
      && (int_isq_occ == $past(int_isq_occ) - $past(int_isq_free_num))
      && (mem_isq_occ == $past(mem_isq_occ) - $past(mem_isq_free_num))
      && (sq_occ == $past(sq_occ) - $past(sq_free_num)))
      else $error("state moved during a stall");

endmodule

bind dispatch_stage dispatch_stage_asserts asserts_i (
   .*,
   .rob_occ     (rob_alloc_i.occ),
   .int_isq_occ (int_isq_alloc_i.occ),
   .mem_isq_occ (mem_isq_alloc_i.occ),
   .sq_occ      (sq_alloc_i.occ)
);

// ==== sim/dispatch_stage_tb.sv ====
`timescale 1ns/1ps

module dispatch_stage_tb
   import dispatch_cfg_pkg::*;
   import ooo_types_pkg::*;
();

   localparam int STALL_LIMIT = 64;

   logic clk, rst_n;
   logic instr0_valid, instr0_mem_read, instr0_mem_write;
   logic instr1_valid, instr1_mem_read, instr1_mem_write;
   preg_t instr0_T, instr0_T_old, instr0_src1, instr0_src2;
   preg_t instr1_T, instr1_T_old, instr1_src1, instr1_src2;
   pair_cnt_t rob_free_num, int_isq_free_num, mem_isq_free_num, sq_free_num;
   logic wb_valid;
   preg_t wb_tag;
   logic can_dispatch, instr0_valid_rob, instr1_valid_rob;
   logic instr0_valid_intisq, instr1_valid_intisq, instr0_valid_memisq, instr1_valid_memisq;
   rob_id_t instr0_robid, instr1_robid;
   sq_id_t instr0_sqid, instr1_sqid;
   preg_t instr0_T_rob, instr0_T_old_rob, instr1_T_rob, instr1_T_old_rob;
   logic instr0_src1_busy, instr0_src2_busy, instr1_src1_busy, instr1_src2_busy;

   // model state, index 0 rob, 1 int queue, 2 mem queue, 3 store queue
   int seed;
   int occ [4];
   int rob_tail, sq_tail;
   bit busy_m [PRF_DEPTH];
   bit held;
   int stall_run;

   dispatch_stage dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      if (r < 0) r = -(r + 1);
      return r % n;
   endfunction

   // small tag range half the time so bypass and set-over-clear get hit
   function automatic preg_t pick_tag();
      if (rand_below(2) == 0) return preg_t'(rand_below(8));
      return preg_t'(rand_below(PRF_DEPTH));
   endfunction

   function automatic int depth_of(input int k);
      case (k)
         0: return ROB_DEPTH;
         1: return INT_ISQ_DEPTH;
         2: return MEM_ISQ_DEPTH;
         default: return SQ_DEPTH;
      endcase
   endfunction

   function automatic int left_of(input int k);
      int f;
      f = depth_of(k) - occ[k];
      return (f > 2) ? 2 : f;
   endfunction

   function automatic pair_cnt_t pick_free(input int k);
      int n;
      n = rand_below(3);
      if (n > occ[k]) n = occ[k];
      return pair_cnt_t'(n);
   endfunction

   function automatic bit src_busy(input preg_t s, input bit byp);
      bit b;
      b = busy_m[s] && !(wb_valid && (wb_tag == s));
      if (byp && (instr0_T == s)) b = 1'b1;
      return b;
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
         $display("TB FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("TB FAILED");
      $fatal(1, "%s", what);
   endtask

   task automatic pick_slot(input int mem_pct, output bit v, output bit rd, output bit wr);
      bit m;
      int k;
      v = (rand_below(8) != 0);
      m = (rand_below(100) < mem_pct);
      // 0 load, 1 store, 2 both bits set
      k = rand_below(3);
      rd = m && (k != 1);
      wr = m && (k != 0);
   endtask

   task automatic drive_inputs(input bit frees_on, input int mem_pct);
      bit v, rd, wr;
      preg_t t0;
      t0 = held ? instr0_T : pick_tag();
      // rename holds a stalled pair
      if (!held) begin
         pick_slot(mem_pct, v, rd, wr);
         instr0_valid <= v;
         instr0_mem_read <= rd;
         instr0_mem_write <= wr;
         pick_slot(mem_pct, v, rd, wr);
         instr1_valid <= v;
         instr1_mem_read <= rd;
         instr1_mem_write <= wr;
         instr0_T <= t0;
         instr0_T_old <= pick_tag();
         instr0_src1 <= pick_tag();
         instr0_src2 <= pick_tag();
         instr1_T <= pick_tag();
         instr1_T_old <= pick_tag();
         instr1_src1 <= (rand_below(4) == 0) ? t0 : pick_tag();
         instr1_src2 <= pick_tag();
      end
      rob_free_num <= frees_on ? pick_free(0) : 2'd0;
      int_isq_free_num <= frees_on ? pick_free(1) : 2'd0;
      mem_isq_free_num <= frees_on ? pick_free(2) : 2'd0;
      sq_free_num <= frees_on ? pick_free(3) : 2'd0;
      wb_valid <= (rand_below(2) == 0);
      wb_tag <= (rand_below(4) == 0) ? t0 : pick_tag();
   endtask

   task automatic check_and_update();
      bit m0, m1, i0, i1, exp_can, a0, a1;
      int nv, nm, ni;
      m0 = instr0_valid && (instr0_mem_read || instr0_mem_write);
      m1 = instr1_valid && (instr1_mem_read || instr1_mem_write);
      i0 = instr0_valid && !m0;
      i1 = instr1_valid && !m1;
      nv = int'(instr0_valid) + int'(instr1_valid);
      nm = int'(m0) + int'(m1);
      ni = int'(i0) + int'(i1);
      exp_can = (left_of(0) >= nv) && (left_of(1) >= ni) && (left_of(2) >= nm)
                && (left_of(3) >= nm);
      a0 = instr0_valid && exp_can;
      a1 = instr1_valid && exp_can;
      check_value("can_dispatch", int'(exp_can), int'(can_dispatch));
      check_value("valid_rob0", int'(a0), int'(instr0_valid_rob));
      check_value("valid_rob1", int'(a1), int'(instr1_valid_rob));
      check_value("valid_intisq0", int'(a0 && i0), int'(instr0_valid_intisq));
      check_value("valid_intisq1", int'(a1 && i1), int'(instr1_valid_intisq));
      check_value("valid_memisq0", int'(a0 && m0), int'(instr0_valid_memisq));
      check_value("valid_memisq1", int'(a1 && m1), int'(instr1_valid_memisq));
      check_value("robid0", rob_tail, int'(instr0_robid));
      check_value("robid1", (rob_tail + int'(a0)) % (2 * ROB_DEPTH), int'(instr1_robid));
      check_value("sqid0", sq_tail, int'(instr0_sqid));
      check_value("sqid1", (sq_tail + int'(a0 && m0)) % SQ_DEPTH, int'(instr1_sqid));
      check_value("T_rob0", int'(instr0_T), int'(instr0_T_rob));
      check_value("T_old_rob0", int'(instr0_T_old), int'(instr0_T_old_rob));
      check_value("T_rob1", int'(instr1_T), int'(instr1_T_rob));
      check_value("T_old_rob1", int'(instr1_T_old), int'(instr1_T_old_rob));
      check_value("src1_busy0", int'(src_busy(instr0_src1, 1'b0)), int'(instr0_src1_busy));
      check_value("src2_busy0", int'(src_busy(instr0_src2, 1'b0)), int'(instr0_src2_busy));
      check_value("src1_busy1", int'(src_busy(instr1_src1, a0)), int'(instr1_src1_busy));
      check_value("src2_busy1", int'(src_busy(instr1_src2, a0)), int'(instr1_src2_busy));
      // state after the coming edge
      occ[0] = occ[0] - int'(rob_free_num) + int'(a0) + int'(a1);
      occ[1] = occ[1] - int'(int_isq_free_num) + int'(a0 && i0) + int'(a1 && i1);
      occ[2] = occ[2] - int'(mem_isq_free_num) + int'(a0 && m0) + int'(a1 && m1);
      occ[3] = occ[3] - int'(sq_free_num) + int'(a0 && m0) + int'(a1 && m1);
      rob_tail = (rob_tail + int'(a0) + int'(a1)) % (2 * ROB_DEPTH);
      sq_tail = (sq_tail + int'(a0 && m0) + int'(a1 && m1)) % SQ_DEPTH;
      if (wb_valid) busy_m[wb_tag] = 1'b0;
      if (a0) busy_m[instr0_T] = 1'b1;
      if (a1) busy_m[instr1_T] = 1'b1;
      held = !exp_can;
      stall_run = held ? stall_run + 1 : 0;
   endtask

   task automatic step(input bit frees_on, input int mem_pct);
      @(posedge clk);
      drive_inputs(frees_on, mem_pct);
      @(negedge clk);
      check_and_update();
      if (frees_on && (stall_run > STALL_LIMIT)) begin
         fail_timeout("pair stalled too long with frees running");
      end
   endtask

   task automatic wait_accept();
      int n;
      n = 0;
      stall_run = 0;
      while (held) begin
         if (n == STALL_LIMIT) fail_timeout("stalled pair was never accepted after frees");
         step(1'b1, 50);
         n++;
      end
   endtask

   initial begin
      seed = 36253;
      // a load and a store wait through reset
      {instr0_valid, instr0_mem_read, instr0_mem_write} = 3'b110;
      {instr1_valid, instr1_mem_read, instr1_mem_write} = 3'b101;
      {instr0_T, instr0_T_old, instr0_src1, instr0_src2} = '0;
      {instr1_T, instr1_T_old, instr1_src1, instr1_src2} = '0;
      {rob_free_num, int_isq_free_num, mem_isq_free_num, sq_free_num} = '0;
      wb_valid = 1'b0;
      wb_tag = '0;
      rst_n = 1'b0;
      occ = '{0, 0, 0, 0};
      rob_tail = 0;
      sq_tail = 0;
      foreach (busy_m[i]) busy_m[i] = 1'b0;
      held = 1'b0;
      stall_run = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("reset_can_dispatch", 1, int'(can_dispatch));
      check_value("reset_robid0", 0, int'(instr0_robid));
      check_value("reset_sqid0", 0, int'(instr0_sqid));
      check_and_update();
      repeat (20) step(1'b1, 50);
      // no frees, memory heavy, so the small queues fill
      repeat (40) step(1'b0, 75);
      check_value("stall_held", 1, int'(held));
      wait_accept();
      repeat (400) step(1'b1, 50);
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== dispatch_stage.f ====
rtl/dispatch_cfg_pkg.sv
rtl/ooo_types_pkg.sv
rtl/dispatch.sv
rtl/slot_allocator.sv
rtl/busy_table.sv
rtl/dispatch_stage.sv
sim/dispatch_stage_asserts.sv
sim/dispatch_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dispatch_stage_tb
FILELIST  ?= dispatch_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
